// File: udp_pkg.sv
`default_nettype none

package udp_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] port_t;
  typedef logic [31:0] ip_t;
  typedef logic [15:0] len_t;

  // the udp header is source port, destination port, length and checksum.
  localparam int HDR_LEN     = 8;
  localparam int MAX_PAYLOAD = 64;
  localparam int BUF_AW      = $clog2(MAX_PAYLOAD);

  localparam port_t LEASE_CLI_PORT = 16'd68;
  localparam port_t LEASE_SRV_PORT = 16'd67;

  localparam int                             LEASE_REQ_LEN = 4;
  localparam logic [0:LEASE_REQ_LEN-1][7:0] LEASE_REQ     = "DISC";

  // timeout is counted in clock cycles from the end of a request.
  localparam int LEASE_TIMEOUT = 200;
  localparam int LEASE_RETRIES = 3;

  localparam ip_t BCAST_IP = '1;

  typedef enum logic [1:0] {
    SEND,
    WAIT,
    DONE,
    FAIL
  } lease_state_t;

endpackage : udp_pkg

`default_nettype wire

// File: udp_strm_if.sv
`default_nettype none

interface udp_strm_if;

  logic           val;
  udp_pkg::byte_t dat;
  logic           sof;
  logic           eof;

  modport src (
    output val,
    output dat,
    output sof,
    output eof
  );

  modport snk (
    input val,
    input dat,
    input sof,
    input eof
  );

endinterface : udp_strm_if

`default_nettype wire

// File: udp_tx_buf.sv
`default_nettype none

module udp_tx_buf (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           in_val,
  input  logic           in_last,
  input  udp_pkg::byte_t in_dat,
  input  udp_pkg::ip_t   in_dst_ip,
  input  udp_pkg::port_t in_dst_port,
  input  udp_pkg::len_t  rd_idx,
  input  logic           done,
  output udp_pkg::byte_t rd_dat,
  output logic           job_rdy,
  output udp_pkg::len_t  job_len,
  output udp_pkg::ip_t   job_ip,
  output udp_pkg::port_t job_port,
  output logic           busy
);

  udp_pkg::byte_t mem [udp_pkg::MAX_PAYLOAD];
  udp_pkg::len_t  wr_cnt;
  logic           full;
  logic           wr;
  logic           room;

  // a full buffer ignores the user until the framer reports the frame sent.
  assign wr   = in_val && !full;
  assign room = wr_cnt < udp_pkg::len_t'(udp_pkg::MAX_PAYLOAD);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full   <= 1'b0;
      wr_cnt <= '0;
    end else begin
      if (done) begin
        full <= 1'b0;
      end else if (wr && in_last) begin
        full <= 1'b1;
      end
      if (wr) begin
        if (in_last) begin
          wr_cnt <= '0;
        end else if (room) begin
          wr_cnt <= wr_cnt + 16'd1;
        end
      end
    end
  end

  // bytes past the buffer size are lost and the length saturates.
  always_ff @(posedge clk) begin
    if (wr && room) begin
      mem[wr_cnt[udp_pkg::BUF_AW-1:0]] <= in_dat;
    end
    if (wr && in_last) begin
      job_len  <= room ? wr_cnt + 16'd1 : wr_cnt;
      job_ip   <= in_dst_ip;
      job_port <= in_dst_port;
    end
  end

  assign rd_dat  = mem[rd_idx[udp_pkg::BUF_AW-1:0]];
  assign job_rdy = full;
  assign busy    = full;

endmodule : udp_tx_buf

`default_nettype wire

// File: udp_tx_frame.sv
`default_nettype none

module udp_tx_frame (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           job_rdy,
  input  udp_pkg::len_t  job_len,
  input  udp_pkg::ip_t   job_ip,
  input  udp_pkg::port_t job_port,
  input  udp_pkg::byte_t rd_dat,
  output udp_pkg::len_t  rd_idx,
  output logic           done,
  input  udp_pkg::port_t loc_port,
  input  logic           lease_req,
  input  logic           lease_ready,
  input  udp_pkg::byte_t lease_dat,
  output udp_pkg::len_t  lease_idx,
  output logic           lease_sent,
  udp_strm_if.src        tx,
  output udp_pkg::ip_t   tx_dst_ip
);

  logic           active;
  logic           sel_q;
  logic           cur_lease;
  logic           start;
  logic           last;
  udp_pkg::len_t  cnt;
  udp_pkg::len_t  idx;
  udp_pkg::len_t  udp_len;
  udp_pkg::len_t  pidx;
  udp_pkg::port_t src_port;
  udp_pkg::port_t dst_port;
  udp_pkg::byte_t nxt_dat;

  // the lease client owns the stream until it is ready or has given up.
  assign cur_lease = active ? sel_q : !lease_ready;
  // the eof cycle is skipped so the source can release its request first.
  assign start     = !active && !tx.eof && (cur_lease ? lease_req : job_rdy);

  assign idx      = active ? cnt : '0;
  assign udp_len  = (cur_lease ? udp_pkg::len_t'(udp_pkg::LEASE_REQ_LEN) : job_len) +
                    udp_pkg::len_t'(udp_pkg::HDR_LEN);
  assign last     = idx == udp_len - 16'd1;
  assign pidx     = idx - udp_pkg::len_t'(udp_pkg::HDR_LEN);
  assign rd_idx    = pidx;
  assign lease_idx = pidx;
  assign src_port = cur_lease ? udp_pkg::LEASE_CLI_PORT : loc_port;
  assign dst_port = cur_lease ? udp_pkg::LEASE_SRV_PORT : job_port;

  always_comb begin
    case (idx)
      16'd0:   nxt_dat = src_port[15:8];
      16'd1:   nxt_dat = src_port[7:0];
      16'd2:   nxt_dat = dst_port[15:8];
      16'd3:   nxt_dat = dst_port[7:0];
      16'd4:   nxt_dat = udp_len[15:8];
      16'd5:   nxt_dat = udp_len[7:0];
      16'd6,
      16'd7:   nxt_dat = '0;
      default: nxt_dat = cur_lease ? lease_dat : rd_dat;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active     <= 1'b0;
      sel_q      <= 1'b0;
      cnt        <= '0;
      tx.val     <= 1'b0;
      tx.sof     <= 1'b0;
      tx.eof     <= 1'b0;
      done       <= 1'b0;
      lease_sent <= 1'b0;
    end else begin
      tx.sof     <= start;
      tx.val     <= start || active;
      tx.eof     <= (start || active) && last;
      done       <= (start || active) && last && !cur_lease;
      lease_sent <= (start || active) && last && cur_lease;
      if (start || active) begin
        cnt    <= idx + 16'd1;
        active <= !last;
      end
      if (start) begin
        sel_q <= cur_lease;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start || active) begin
      tx.dat <= nxt_dat;
    end
    if (start) begin
      tx_dst_ip <= cur_lease ? udp_pkg::BCAST_IP : job_ip;
    end
  end

endmodule : udp_tx_frame

`default_nettype wire

// File: udp_rx_parse.sv
`default_nettype none

module udp_rx_parse (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           rx_val,
  input  logic           rx_sof,
  input  logic           rx_eof,
  input  udp_pkg::byte_t rx_dat,
  input  udp_pkg::ip_t   rx_src_ip,
  input  udp_pkg::port_t loc_port,
  udp_strm_if.src        usr_rx,
  udp_strm_if.src        lease_rx,
  output udp_pkg::port_t src_port,
  output udp_pkg::ip_t   src_ip
);

  logic [3:0]     hcnt;
  logic [3:0]     pos;
  udp_pkg::port_t hdr_src;
  udp_pkg::port_t hdr_dst;
  udp_pkg::len_t  hdr_len;
  udp_pkg::len_t  rem;
  logic           to_usr;
  logic           to_lease;
  logic           pay;
  logic           first;
  logic           fin;

  // pos saturates at the header length, which marks the payload phase.
  assign pos   = rx_sof ? 4'd0 : hcnt;
  assign pay   = rx_val && pos == 4'(udp_pkg::HDR_LEN) && rem != '0;
  assign first = rem == hdr_len - udp_pkg::len_t'(udp_pkg::HDR_LEN);
  assign fin   = rem == 16'd1 || rx_eof;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hcnt         <= 4'(udp_pkg::HDR_LEN);
      rem          <= '0;
      usr_rx.val   <= 1'b0;
      usr_rx.sof   <= 1'b0;
      usr_rx.eof   <= 1'b0;
      lease_rx.val <= 1'b0;
      lease_rx.sof <= 1'b0;
      lease_rx.eof <= 1'b0;
    end else begin
      usr_rx.val   <= pay && to_usr;
      usr_rx.sof   <= pay && to_usr && first;
      usr_rx.eof   <= pay && to_usr && fin;
      lease_rx.val <= pay && to_lease;
      lease_rx.sof <= pay && to_lease && first;
      lease_rx.eof <= pay && to_lease && fin;
      if (rx_val) begin
        if (pos != 4'(udp_pkg::HDR_LEN)) begin
          hcnt <= pos + 4'd1;
        end
        // padding past the length field never reaches a sink.
        if (pos == 4'd7) begin
          rem <= (hdr_len > udp_pkg::len_t'(udp_pkg::HDR_LEN)) ?
                 hdr_len - udp_pkg::len_t'(udp_pkg::HDR_LEN) : '0;
        end else if (pay) begin
          rem <= rx_eof ? '0 : rem - 16'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_val) begin
      case (pos)
        4'd0: hdr_src[15:8] <= rx_dat;
        4'd1: hdr_src[7:0]  <= rx_dat;
        4'd2: hdr_dst[15:8] <= rx_dat;
        4'd3: hdr_dst[7:0]  <= rx_dat;
        4'd4: hdr_len[15:8] <= rx_dat;
        4'd5: hdr_len[7:0]  <= rx_dat;
        4'd7: begin
          to_lease <= hdr_dst == udp_pkg::LEASE_CLI_PORT;
          to_usr   <= hdr_dst == loc_port && hdr_dst != udp_pkg::LEASE_CLI_PORT;
        end
        default: ;
      endcase
    end
    if (pay) begin
      usr_rx.dat   <= rx_dat;
      lease_rx.dat <= rx_dat;
    end
    if (pay && first) begin
      src_port <= hdr_src;
      src_ip   <= rx_src_ip;
    end
  end

endmodule : udp_rx_parse

`default_nettype wire

// File: udp_lease.sv
`default_nettype none

module udp_lease (
  input  logic           clk,
  input  logic           rst_n,
  udp_strm_if.snk        rx,
  input  logic           tx_eof,
  input  logic           sent,
  input  udp_pkg::len_t  lease_idx,
  output udp_pkg::byte_t lease_dat,
  output logic           lease_req,
  output logic           lease_ready,
  output logic           lease_fail,
  output udp_pkg::ip_t   lease_ip
);

  udp_pkg::lease_state_t state;
  udp_pkg::len_t         tmr;
  udp_pkg::len_t         tries;
  logic [2:0]            bcnt;
  logic [2:0]            bcnt_nxt;
  udp_pkg::ip_t          ip_sh;
  udp_pkg::ip_t          ip_nxt;
  logic                  take;
  logic                  reply_ok;
  logic                  expired;

  // only the first four reply bytes form the address.
  assign take     = rx.val && (rx.sof || bcnt < 3'd4);
  assign bcnt_nxt = rx.sof ? 3'd1 : ((bcnt < 3'd4) ? bcnt + 3'd1 : bcnt);
  assign ip_nxt   = take ? {ip_sh[23:0], rx.dat} : ip_sh;
  assign reply_ok = rx.val && rx.eof && bcnt_nxt == 3'd4;
  assign expired  = tmr == udp_pkg::len_t'(udp_pkg::LEASE_TIMEOUT - 1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= udp_pkg::SEND;
      tmr      <= '0;
      tries    <= '0;
      bcnt     <= '0;
      lease_ip <= '0;
    end else begin
      if (rx.val) begin
        bcnt <= bcnt_nxt;
      end
      if (tx_eof) begin
        tmr <= '0;
      end else if (state == udp_pkg::WAIT) begin
        tmr <= tmr + 16'd1;
      end
      if ((state == udp_pkg::SEND || state == udp_pkg::WAIT) && reply_ok) begin
        state    <= udp_pkg::DONE;
        lease_ip <= ip_nxt;
      end else begin
        case (state)
          udp_pkg::SEND: begin
            if (sent) begin
              tries <= tries + 16'd1;
              state <= udp_pkg::WAIT;
            end
          end
          udp_pkg::WAIT: begin
            if (expired) begin
              state <= (tries == udp_pkg::len_t'(udp_pkg::LEASE_RETRIES)) ?
                       udp_pkg::FAIL : udp_pkg::SEND;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      ip_sh <= ip_nxt;
    end
  end

  assign lease_dat   = udp_pkg::LEASE_REQ[lease_idx[1:0]];
  assign lease_req   = state == udp_pkg::SEND;
  assign lease_ready = state == udp_pkg::DONE || state == udp_pkg::FAIL;
  assign lease_fail  = state == udp_pkg::FAIL;

endmodule : udp_lease

`default_nettype wire

// File: udp_top.sv
`default_nettype none

module udp_top (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           in_val,
  input  logic           in_last,
  input  udp_pkg::byte_t in_dat,
  input  udp_pkg::ip_t   in_dst_ip,
  input  udp_pkg::port_t in_dst_port,
  input  udp_pkg::port_t loc_port,
  input  logic           rx_val,
  input  logic           rx_sof,
  input  logic           rx_eof,
  input  udp_pkg::byte_t rx_dat,
  input  udp_pkg::ip_t   rx_src_ip,
  output logic           tx_val,
  output logic           tx_sof,
  output logic           tx_eof,
  output udp_pkg::byte_t tx_dat,
  output udp_pkg::ip_t   tx_dst_ip,
  output logic           out_val,
  output logic           out_sof,
  output logic           out_eof,
  output udp_pkg::byte_t out_dat,
  output udp_pkg::port_t out_src_port,
  output udp_pkg::ip_t   out_src_ip,
  output logic           busy,
  output logic           lease_ready,
  output logic           lease_fail,
  output udp_pkg::ip_t   lease_ip
);

  udp_strm_if tx_s ();
  udp_strm_if usr_s ();
  udp_strm_if lease_s ();

  udp_pkg::len_t  rd_idx;
  udp_pkg::byte_t rd_dat;
  logic           done;
  logic           job_rdy;
  udp_pkg::len_t  job_len;
  udp_pkg::ip_t   job_ip;
  udp_pkg::port_t job_port;
  logic           lease_req;
  logic           lease_sent;
  udp_pkg::len_t  lease_idx;
  udp_pkg::byte_t lease_dat;

  udp_tx_buf udp_tx_buf_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_val      (in_val),
    .in_last     (in_last),
    .in_dat      (in_dat),
    .in_dst_ip   (in_dst_ip),
    .in_dst_port (in_dst_port),
    .rd_idx      (rd_idx),
    .done        (done),
    .rd_dat      (rd_dat),
    .job_rdy     (job_rdy),
    .job_len     (job_len),
    .job_ip      (job_ip),
    .job_port    (job_port),
    .busy        (busy)
  );

  // the framer serves the lease client first, then the user buffer.
  udp_tx_frame udp_tx_frame_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .job_rdy     (job_rdy),
    .job_len     (job_len),
    .job_ip      (job_ip),
    .job_port    (job_port),
    .rd_dat      (rd_dat),
    .rd_idx      (rd_idx),
    .done        (done),
    .loc_port    (loc_port),
    .lease_req   (lease_req),
    .lease_ready (lease_ready),
    .lease_dat   (lease_dat),
    .lease_idx   (lease_idx),
    .lease_sent  (lease_sent),
    .tx          (tx_s.src),
    .tx_dst_ip   (tx_dst_ip)
  );

  udp_rx_parse udp_rx_parse_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_val    (rx_val),
    .rx_sof    (rx_sof),
    .rx_eof    (rx_eof),
    .rx_dat    (rx_dat),
    .rx_src_ip (rx_src_ip),
    .loc_port  (loc_port),
    .usr_rx    (usr_s.src),
    .lease_rx  (lease_s.src),
    .src_port  (out_src_port),
    .src_ip    (out_src_ip)
  );

  udp_lease udp_lease_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .rx          (lease_s.snk),
    .tx_eof      (tx_s.eof),
    .sent        (lease_sent),
    .lease_idx   (lease_idx),
    .lease_dat   (lease_dat),
    .lease_req   (lease_req),
    .lease_ready (lease_ready),
    .lease_fail  (lease_fail),
    .lease_ip    (lease_ip)
  );

  assign tx_val  = tx_s.val;
  assign tx_sof  = tx_s.sof;
  assign tx_eof  = tx_s.eof;
  assign tx_dat  = tx_s.dat;
  assign out_val = usr_s.val;
  assign out_sof = usr_s.sof;
  assign out_eof = usr_s.eof;
  assign out_dat = usr_s.dat;

endmodule : udp_top

`default_nettype wire

// File: udp_asserts.sv
`default_nettype none

module udp_asserts (
  input logic clk,
  input logic rst_n,
  input logic tx_val,
  input logic tx_sof,
  input logic tx_eof,
  input logic busy,
  input logic lease_ready
);

  timeunit 1ns;
  timeprecision 1ps;

  logic in_frame;

  // in_frame is high between a start byte and its end byte.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_frame <= 1'b0;
    end else if (tx_val && tx_eof) begin
      in_frame <= 1'b0;
    end else if (tx_val && tx_sof) begin
      in_frame <= 1'b1;
    end
  end

  a_val_needs_sof: assert property (@(posedge clk) disable iff (!rst_n)
    tx_val && !in_frame |-> tx_sof) else $error("tx_val outside a frame");

  a_no_nested_sof: assert property (@(posedge clk) disable iff (!rst_n)
    tx_sof |-> !in_frame) else $error("tx_sof before the previous tx_eof");

  a_eof_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
    tx_eof |-> in_frame || tx_sof) else $error("tx_eof without tx_sof");

  a_busy_until_eof: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy) |-> $past(tx_eof)) else $error("busy fell before tx_eof");

  a_ready_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    !$fell(lease_ready)) else $error("lease_ready fell");

endmodule : udp_asserts

bind udp_top udp_asserts asserts_inst (.*);

`default_nettype wire

// File: tb_udp_top.sv
`default_nettype none

module tb_udp_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int K_LEASE = 0;
  localparam int K_EARLY = 1;
  localparam int K_REPLY = 2;
  localparam int K_PEND  = 3;
  localparam int K_USER  = 4;
  localparam int K_RX    = 5;
  localparam int K_RESET = 6;
  localparam int K_FAIL  = 7;
  localparam int NSTEPS  = 14;
  localparam udp_pkg::port_t LOC = 16'h1234;

  typedef struct packed {
    logic [2:0]  kind;
    logic [6:0]  n;
    logic [15:0] port;
    logic [31:0] ip;
    logic [3:0]  pad;
  } step_t;

  logic clk;
  logic rst_n;
  logic in_val;
  logic in_last;
  udp_pkg::byte_t in_dat;
  udp_pkg::ip_t in_dst_ip;
  udp_pkg::port_t in_dst_port;
  udp_pkg::port_t loc_port;
  logic rx_val;
  logic rx_sof;
  logic rx_eof;
  udp_pkg::byte_t rx_dat;
  udp_pkg::ip_t rx_src_ip;
  logic tx_val;
  logic tx_sof;
  logic tx_eof;
  udp_pkg::byte_t tx_dat;
  udp_pkg::ip_t tx_dst_ip;
  logic out_val;
  logic out_sof;
  logic out_eof;
  udp_pkg::byte_t out_dat;
  udp_pkg::port_t out_src_port;
  udp_pkg::ip_t out_src_ip;
  logic busy;
  logic lease_ready;
  logic lease_fail;
  udp_pkg::ip_t lease_ip;

  step_t steps [NSTEPS];
  udp_pkg::byte_t exp_pay [udp_pkg::MAX_PAYLOAD];
  udp_pkg::byte_t rx_pay [udp_pkg::MAX_PAYLOAD];
  udp_pkg::byte_t lreq [4];
  udp_pkg::byte_t fr_bytes [$];
  int fr_len [$];
  udp_pkg::ip_t fr_ip [$];
  int fr_sof [$];
  udp_pkg::byte_t out_q [$];
  int cyc;
  int cur_n;
  int cur_sof;
  udp_pkg::ip_t cur_ip;
  int user_last_cyc;
  int popped_sof;
  int out_sof_n;
  int out_sof_pos;
  int out_eof_n;
  int out_eof_pos;
  udp_pkg::port_t got_sport;
  udp_pkg::ip_t got_sip;
  logic [31:0] rng;

  udp_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // frames and user output are collected at the falling edge.
  always @(negedge clk) begin
    if (!rst_n) begin
      fr_bytes.delete();
      fr_len.delete();
      fr_ip.delete();
      fr_sof.delete();
      cur_n = 0;
    end else begin
      if (in_val && in_last && !busy) user_last_cyc = cyc;
      if (tx_val) begin
        if (tx_sof) begin
          cur_n = 0;
          cur_sof = cyc;
          cur_ip = tx_dst_ip;
        end else begin
          check_value("tx_dst_ip", tx_dst_ip, cur_ip);
        end
        fr_bytes.push_back(tx_dat);
        cur_n++;
        if (tx_eof) begin
          fr_len.push_back(cur_n);
          fr_ip.push_back(cur_ip);
          fr_sof.push_back(cur_sof);
        end
      end
      if (out_val) begin
        out_q.push_back(out_dat);
        if (out_sof) begin
          out_sof_n++;
          out_sof_pos = out_q.size();
        end
        if (out_eof) begin
          out_eof_n++;
          out_eof_pos = out_q.size();
          got_sport = out_src_port;
          got_sip = out_src_ip;
        end
      end
    end
  end

  initial begin
    repeat (NSTEPS * 1000) @(posedge clk);
    fail_now("watchdog expired, the run did not finish");
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else
      fail_now($sformatf("** Error %s: got %h expected %h", name, got, exp));
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic step_t mk(input int kind, input int n, input logic [15:0] port,
                               input logic [31:0] ip, input int pad);
    step_t s;
    s.kind = 3'(kind);
    s.n = 7'(n);
    s.port = port;
    s.ip = ip;
    s.pad = 4'(pad);
    return s;
  endfunction

  // header fields are big-endian and the checksum is always zero.
  function automatic udp_pkg::byte_t hdr_byte(input int k, input logic [15:0] src,
                                              input logic [15:0] dst, input int n);
    logic [15:0] len;
    len = 16'(n + 8);
    case (k)
      0: return src[15:8];
      1: return src[7:0];
      2: return dst[15:8];
      3: return dst[7:0];
      4: return len[15:8];
      5: return len[7:0];
      default: return 8'h00;
    endcase
  endfunction

  task automatic fill_pay(input int n, input bit to_rx);
    for (int i = 0; i < n; i++) begin
      rng = xorshift(rng);
      if (to_rx) rx_pay[i] = rng[7:0];
      else exp_pay[i] = rng[7:0];
    end
  endtask

  task automatic drive_user(input int n, input logic [15:0] port, input logic [31:0] ip,
                            input udp_pkg::byte_t flip);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      in_val <= 1'b1;
      in_dat <= exp_pay[i] ^ flip;
      in_last <= (i == n - 1);
      in_dst_ip <= ip;
      in_dst_port <= port;
    end
    @(posedge clk);
    in_val <= 1'b0;
    in_last <= 1'b0;
  endtask

  task automatic drive_rx(input logic [15:0] dst, input logic [15:0] src,
                          input logic [31:0] sip, input int n, input int pad);
    int total;
    total = 8 + n + pad;
    for (int k = 0; k < total; k++) begin
      @(posedge clk);
      rx_val <= 1'b1;
      rx_sof <= (k == 0);
      rx_eof <= (k == total - 1);
      rx_src_ip <= sip;
      if (k < 8) rx_dat <= hdr_byte(k, src, dst, n);
      else if (k < 8 + n) rx_dat <= rx_pay[k - 8];
      else rx_dat <= 8'hee;
    end
    @(posedge clk);
    rx_val <= 1'b0;
    rx_sof <= 1'b0;
    rx_eof <= 1'b0;
  endtask

  task automatic wait_frame(input int limit);
    int t;
    t = 0;
    while (fr_len.size() == 0 && t < limit) begin
      @(posedge clk);
      t++;
    end
    assert (fr_len.size() != 0) else fail_now("timeout waiting for a transmit frame");
  endtask

  task automatic check_frame(input logic [15:0] src, input logic [15:0] dst, input int n,
                             input logic [31:0] ip, input bit is_lease);
    int len;
    udp_pkg::byte_t got;
    udp_pkg::byte_t exp;
    len = fr_len.pop_front();
    popped_sof = fr_sof.pop_front();
    check_value("frame length", len, n + 8);
    check_value("tx_dst_ip", fr_ip.pop_front(), ip);
    for (int k = 0; k < len; k++) begin
      got = fr_bytes.pop_front();
      if (k < 8) exp = hdr_byte(k, src, dst, n);
      else if (is_lease) exp = lreq[k - 8];
      else exp = exp_pay[k - 8];
      check_value($sformatf("tx_dat[%0d]", k), got, exp);
    end
  endtask

  task automatic check_lease_frame(input int limit);
    wait_frame(limit);
    check_frame(16'd68, 16'd67, 4, 32'hffff_ffff, 1'b1);
  endtask

  initial begin
    step_t s;
    int n;
    int ready_cyc;
    int prev_sof;
    bit have_prev;
    int pend_n;
    logic [15:0] pend_port;
    logic [31:0] pend_ip;
    int t;
    rst_n = 1'b0;
    in_val = 1'b0;
    in_last = 1'b0;
    in_dat = '0;
    in_dst_ip = '0;
    in_dst_port = '0;
    loc_port = LOC;
    rx_val = 1'b0;
    rx_sof = 1'b0;
    rx_eof = 1'b0;
    rx_dat = '0;
    rx_src_ip = '0;
    cyc = 0;
    rng = 32'hc619;
    have_prev = 1'b0;
    lreq = '{8'h44, 8'h49, 8'h53, 8'h43};
    steps[0] = mk(K_LEASE, 0, 16'h0, 32'h0, 0);
    steps[1] = mk(K_LEASE, 0, 16'h0, 32'h0, 0);
    steps[2] = mk(K_EARLY, 10, 16'h0401, 32'h0a00_0001, 0);
    steps[3] = mk(K_REPLY, 0, 16'h0, 32'hc0a8_0117, 0);
    steps[4] = mk(K_PEND, 0, 16'h0, 32'h0, 0);
    steps[5] = mk(K_USER, 0, 16'h2000, 32'h0a00_0002, 0);
    steps[6] = mk(K_USER, 0, 16'h2001, 32'h0a00_0003, 0);
    steps[7] = mk(K_USER, 64, 16'h2002, 32'h0a00_0004, 0);
    steps[8] = mk(K_RX, 5, LOC, 32'h0a00_0063, 3);
    steps[9] = mk(K_RX, 7, 16'h5555, 32'h0a00_0064, 0);
    steps[10] = mk(K_RX, 20, LOC, 32'h0a00_0065, 0);
    steps[11] = mk(K_RESET, 0, 16'h0, 32'h0, 0);
    steps[12] = mk(K_FAIL, 0, 16'h0, 32'h0, 0);
    steps[13] = mk(K_USER, 0, 16'h2003, 32'h0a00_0005, 0);
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < NSTEPS; i++) begin
      s = steps[i];
      case (int'(s.kind))
        K_LEASE: begin
          check_lease_frame(400);
          if (have_prev) begin
            assert (popped_sof - prev_sof >= udp_pkg::LEASE_TIMEOUT) else
              fail_now("a lease retry came before the timeout");
          end
          prev_sof = popped_sof;
          have_prev = 1'b1;
        end
        K_EARLY: begin
          check_value("lease_ready", lease_ready, 0);
          pend_n = s.n;
          pend_port = s.port;
          pend_ip = s.ip;
          fill_pay(pend_n, 1'b0);
          drive_user(pend_n, pend_port, pend_ip, 8'h00);
          repeat (50) @(posedge clk);
          check_value("frames before lease", fr_len.size(), 0);
        end
        K_REPLY: begin
          out_q.delete();
          for (int k = 0; k < 4; k++) rx_pay[k] = s.ip[31 - 8 * k -: 8];
          drive_rx(16'd68, 16'd67, 32'hc0a8_0101, 4, 0);
          t = 0;
          while (!lease_ready && t < 20) begin
            @(negedge clk);
            t++;
          end
          ready_cyc = cyc;
          check_value("lease_ready", lease_ready, 1);
          check_value("lease_fail", lease_fail, 0);
          check_value("lease_ip", lease_ip, s.ip);
          check_value("out bytes from reply", out_q.size(), 0);
        end
        K_PEND: begin
          wait_frame(100);
          check_frame(LOC, pend_port, pend_n, pend_ip, 1'b0);
          assert (popped_sof > ready_cyc) else
            fail_now("user frame started before lease_ready");
        end
        K_USER: begin
          rng = xorshift(rng);
          n = (s.n == 0) ? 1 + int'(rng % 64) : int'(s.n);
          fill_pay(n, 1'b0);
          drive_user(n, s.port, s.ip, 8'h00);
          @(negedge clk);
          check_value("busy", busy, 1);
          // this datagram arrives while busy and has to be dropped.
          drive_user(3, 16'hdead, 32'hdead_beef, 8'hff);
          wait_frame(200);
          check_frame(LOC, s.port, n, s.ip, 1'b0);
          check_value("tx_sof cycle", popped_sof, user_last_cyc + 2);
          repeat (20) @(posedge clk);
          check_value("extra frames", fr_len.size(), 0);
        end
        K_RX: begin
          out_q.delete();
          out_sof_n = 0;
          out_eof_n = 0;
          fill_pay(s.n, 1'b1);
          drive_rx(s.port, 16'h9abc, s.ip, s.n, s.pad);
          repeat (3) @(posedge clk);
          if (s.port == LOC) begin
            check_value("out byte count", out_q.size(), s.n);
            for (int k = 0; k < int'(s.n); k++)
              check_value($sformatf("out_dat[%0d]", k), out_q[k], rx_pay[k]);
            check_value("out_sof count", out_sof_n, 1);
            check_value("out_sof position", out_sof_pos, 1);
            check_value("out_eof count", out_eof_n, 1);
            check_value("out_eof position", out_eof_pos, s.n);
            check_value("out_src_port", got_sport, 16'h9abc);
            check_value("out_src_ip", got_sip, s.ip);
          end else begin
            check_value("out byte count", out_q.size(), 0);
          end
        end
        K_RESET: begin
          @(posedge clk);
          rst_n <= 1'b0;
          repeat (4) @(posedge clk);
          rst_n <= 1'b1;
          have_prev = 1'b0;
        end
        default: begin
          for (int k = 0; k < udp_pkg::LEASE_RETRIES; k++) check_lease_frame(400);
          t = 0;
          while (!lease_fail && t < 400) begin
            @(negedge clk);
            t++;
          end
          check_value("lease_fail", lease_fail, 1);
          check_value("lease_ready", lease_ready, 1);
          check_value("lease_ip", lease_ip, 0);
          repeat (250) @(posedge clk);
          check_value("requests after fail", fr_len.size(), 0);
        end
      endcase
    end

    $display("Done: no errors");
    $finish;
  end

endmodule : tb_udp_top

`default_nettype wire

// File: all.f
udp_pkg.sv
udp_strm_if.sv
udp_tx_buf.sv
udp_tx_frame.sv
udp_rx_parse.sv
udp_lease.sv
udp_top.sv
udp_asserts.sv
tb_udp_top.sv

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --assert --timing -f all.f --top-module tb_udp_top \
  -o sim_udp && ./obj_dir/sim_udp 2>&1)
echo "$out"
grep -qx "Done: no errors" <<< "$out" && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}
